// File: src/ieu_consts.svh
`ifndef IEU_CONSTS_SVH
`define IEU_CONSTS_SVH

// datapath widths shared by the whole execution unit

// operand and result word
`define IEU_DATA_WIDTH   32

// instruction address
`define IEU_ADDR_WIDTH   32

// reorder buffer index
`define IEU_TAG_WIDTH    5

// operation class from the reservation station
`define IEU_OPCODE_WIDTH 3

`endif

// File: src/ieu_pkg.sv
`include "ieu_consts.svh"

package ieu_pkg;

    typedef logic [`IEU_DATA_WIDTH-1:0] ieu_data_t;
    typedef logic [`IEU_ADDR_WIDTH-1:0] ieu_addr_t;
    typedef logic [`IEU_TAG_WIDTH-1:0]  ieu_tag_t;

    // operation class picked by the reservation station
    typedef enum logic [`IEU_OPCODE_WIDTH-1:0] {
        OP     = 3'd0, // reg-reg alu
        OP_IMM = 3'd1, // reg-imm alu and shifts
        LUI    = 3'd2,
        AUIPC  = 3'd3,
        JAL    = 3'd4,
        JALR   = 3'd5,
        BRANCH = 3'd6
    } ieu_opcode_e;

    typedef enum logic [3:0] {
        ADD  = 4'd0,
        SUB  = 4'd1,
        AND  = 4'd2,
        OR   = 4'd3,
        XOR  = 4'd4,
        SLL  = 4'd5,
        SRL  = 4'd6,
        SRA  = 4'd7,
        SLT  = 4'd8,
        SLTU = 4'd9
    } ieu_alu_func_e;

    // instruction word seen as i-type or b-type
    typedef union packed {
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
        struct packed {
            logic        imm_12;
            logic [5:0]  imm_10_5;
            logic [4:0]  rs2;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [3:0]  imm_4_1;
            logic        imm_11;
            logic [6:0]  opcode;
        } b;
    } ieu_insn_u;

endpackage

// File: src/ieu_decode.sv
`timescale 1ns/1ns
`include "ieu_consts.svh"

module ieu_decode (
    input  logic                   clk,
    input  logic                   i_rst_n,
    input  logic                   i_flush,
    input  logic                   i_valid,
    input  ieu_pkg::ieu_opcode_e   i_opcode,
    input  ieu_pkg::ieu_addr_t     i_iaddr,
    input  ieu_pkg::ieu_data_t     i_insn,
    input  ieu_pkg::ieu_data_t     i_src_a,
    input  ieu_pkg::ieu_data_t     i_src_b,
    input  ieu_pkg::ieu_tag_t      i_tag,
    output ieu_pkg::ieu_alu_func_e o_alu_func,
    output ieu_pkg::ieu_data_t     o_src_a,
    output ieu_pkg::ieu_data_t     o_src_b,
    output ieu_pkg::ieu_data_t     o_imm,
    output ieu_pkg::ieu_addr_t     o_iaddr,
    output ieu_pkg::ieu_tag_t      o_tag,
    output logic [2:0]             o_br_func,
    output logic                   o_jmp,
    output logic                   o_br,
    output logic                   o_valid
);
    import ieu_pkg::*;

    ieu_insn_u     insn;
    ieu_data_t     imm_i;
    ieu_data_t     imm_b;
    ieu_data_t     imm_u;
    ieu_data_t     imm_j;
    logic [2:0]    funct3;
    logic          alt;      // insn bit 30, sub / arithmetic shift
    ieu_alu_func_e alu_func;
    ieu_data_t     src_a;
    ieu_data_t     src_b;
    ieu_data_t     imm;
    logic          jmp;
    logic          br;

    assign insn   = i_insn;
    assign funct3 = insn.i.funct3; // same spot in every format
    assign alt    = i_insn[30];

    // sign-extended immediates
    assign imm_i = {{(`IEU_DATA_WIDTH-12){insn.i.imm[11]}}, insn.i.imm};
    assign imm_b = {{(`IEU_DATA_WIDTH-12){insn.b.imm_12}}, insn.b.imm_11,
                    insn.b.imm_10_5, insn.b.imm_4_1, 1'b0};
    assign imm_u = {i_insn[31:12], 12'b0};
    assign imm_j = {{(`IEU_DATA_WIDTH-20){i_insn[31]}}, i_insn[19:12], i_insn[20],
                    i_insn[30:21], 1'b0};

    always_comb begin
        case (funct3)
            3'b000:  alu_func = (i_opcode == OP && alt) ? SUB : ADD; // no subi
            3'b001:  alu_func = SLL;
            3'b010:  alu_func = SLT;
            3'b011:  alu_func = SLTU;
            3'b100:  alu_func = XOR;
            3'b101:  alu_func = alt ? SRA : SRL;
            3'b110:  alu_func = OR;
            default: alu_func = AND;
        endcase
        // everything outside OP / OP_IMM only needs the adder
        if (i_opcode != OP && i_opcode != OP_IMM) begin
            alu_func = ADD;
        end
    end

    // operand muxing per class
    // br marks a pc-relative target (BRANCH and JAL), jmp an unconditional one
    always_comb begin
        src_a = i_src_a;
        src_b = i_src_b;
        imm   = imm_i;
        jmp   = 1'b0;
        br    = 1'b0;
        case (i_opcode)
            OP_IMM: src_b = imm_i;
            LUI: begin
                src_a = '0;
                src_b = imm_u;
            end
            AUIPC: begin
                src_a = i_iaddr;
                src_b = imm_u;
            end
            JAL: begin
                imm = imm_j;
                jmp = 1'b1;
                br  = 1'b1;
            end
            JALR: begin
                src_b = imm_i; // alu sum gives the target
                jmp   = 1'b1;
            end
            BRANCH: begin
                imm = imm_b;
                br  = 1'b1;
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_valid & ~i_flush; // same-cycle issue dies too
        end
    end

    always_ff @(posedge clk) begin
        o_alu_func <= alu_func;
        o_src_a    <= src_a;
        o_src_b    <= src_b;
        o_imm      <= imm;
        o_iaddr    <= i_iaddr;
        o_tag      <= i_tag;
        o_br_func  <= funct3;
        o_jmp      <= jmp;
        o_br       <= br;
    end

endmodule

// File: src/ieu_execute.sv
`timescale 1ns/1ns
`include "ieu_consts.svh"

module ieu_execute (
    input  logic                   clk,
    input  logic                   i_rst_n,
    input  logic                   i_flush,
    input  logic                   i_valid,
    input  ieu_pkg::ieu_alu_func_e i_alu_func,
    input  ieu_pkg::ieu_data_t     i_src_a,
    input  ieu_pkg::ieu_data_t     i_src_b,
    input  ieu_pkg::ieu_data_t     i_imm,
    input  ieu_pkg::ieu_addr_t     i_iaddr,
    input  ieu_pkg::ieu_tag_t      i_tag,
    input  logic [2:0]             i_br_func,
    input  logic                   i_jmp,
    input  logic                   i_br,
    output ieu_pkg::ieu_data_t     o_data,
    output ieu_pkg::ieu_addr_t     o_addr,
    output ieu_pkg::ieu_tag_t      o_tag,
    output logic                   o_redirect,
    output logic                   o_valid
);
    import ieu_pkg::*;

    ieu_data_t  alu_res;
    logic [4:0] shamt;
    logic       cmp;
    logic       taken;
    ieu_addr_t  link;
    ieu_addr_t  rel_target;
    ieu_addr_t  target;

    assign shamt = i_src_b[4:0];

    always_comb begin
        case (i_alu_func)
            ADD:     alu_res = i_src_a + i_src_b;
            SUB:     alu_res = i_src_a - i_src_b;
            AND:     alu_res = i_src_a & i_src_b;
            OR:      alu_res = i_src_a | i_src_b;
            XOR:     alu_res = i_src_a ^ i_src_b;
            SLL:     alu_res = i_src_a << shamt;
            SRL:     alu_res = i_src_a >> shamt;
            SRA:     alu_res = ieu_data_t'($signed(i_src_a) >>> shamt);
            SLT: begin
                alu_res = {{(`IEU_DATA_WIDTH-1){1'b0}}, $signed(i_src_a) < $signed(i_src_b)};
            end
            SLTU: begin
                alu_res = {{(`IEU_DATA_WIDTH-1){1'b0}}, i_src_a < i_src_b};
            end
            default: alu_res = i_src_a + i_src_b;
        endcase
    end

    // branch condition from funct3
    always_comb begin
        case (i_br_func)
            3'b000:  cmp = (i_src_a == i_src_b);                  // beq
            3'b001:  cmp = (i_src_a != i_src_b);                  // bne
            3'b100:  cmp = ($signed(i_src_a) < $signed(i_src_b));  // blt
            3'b101:  cmp = ($signed(i_src_a) >= $signed(i_src_b)); // bge
            3'b110:  cmp = (i_src_a < i_src_b);                   // bltu
            3'b111:  cmp = (i_src_a >= i_src_b);                  // bgeu
            default: cmp = 1'b0;
        endcase
    end

    assign taken      = i_jmp | (i_br & cmp);
    assign link       = i_iaddr + ieu_addr_t'(4);
    assign rel_target = i_iaddr + i_imm;

    // jalr target is the alu sum with bit 0 dropped
    assign target = i_br ? rel_target : {alu_res[`IEU_ADDR_WIDTH-1:1], 1'b0};

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_valid    <= 1'b0;
            o_redirect <= 1'b0;
        end else begin
            o_valid    <= i_valid & ~i_flush;
            o_redirect <= i_valid & ~i_flush & taken; // never without valid
        end
    end

    always_ff @(posedge clk) begin
        o_tag  <= i_tag;
        o_addr <= taken ? target : link;
        if (i_jmp) begin
            o_data <= link;
        end else if (i_br) begin
            o_data <= '0; // branches write nothing back
        end else begin
            o_data <= alu_res;
        end
    end

endmodule

// File: src/ieu_top.sv
`timescale 1ns/1ns
`include "ieu_consts.svh"

module ieu_top (
    input  logic                 clk,
    input  logic                 i_rst_n,
    input  logic                 i_flush,

    // reservation station issue
    input  logic                 i_fu_valid,
    input  ieu_pkg::ieu_opcode_e i_fu_opcode,
    input  ieu_pkg::ieu_addr_t   i_fu_iaddr,
    input  ieu_pkg::ieu_data_t   i_fu_insn,
    input  ieu_pkg::ieu_data_t   i_fu_src_a,
    input  ieu_pkg::ieu_data_t   i_fu_src_b,
    input  ieu_pkg::ieu_tag_t    i_fu_tag,

    // common data bus
    output logic                 o_cdb_en,
    output logic                 o_cdb_redirect,
    output ieu_pkg::ieu_data_t   o_cdb_data,
    output ieu_pkg::ieu_addr_t   o_cdb_addr,
    output ieu_pkg::ieu_tag_t    o_cdb_tag
);

    // decode -> execute
    ieu_pkg::ieu_alu_func_e alu_func;
    ieu_pkg::ieu_data_t     src_a;
    ieu_pkg::ieu_data_t     src_b;
    ieu_pkg::ieu_data_t     imm;
    ieu_pkg::ieu_addr_t     iaddr;
    ieu_pkg::ieu_tag_t      tag;
    logic [2:0]             br_func;
    logic                   jmp;
    logic                   br;
    logic                   valid;

    ieu_decode decode_i (
        .clk        (clk),
        .i_rst_n    (i_rst_n),
        .i_flush    (i_flush),
        .i_valid    (i_fu_valid),
        .i_opcode   (i_fu_opcode),
        .i_iaddr    (i_fu_iaddr),
        .i_insn     (i_fu_insn),
        .i_src_a    (i_fu_src_a),
        .i_src_b    (i_fu_src_b),
        .i_tag      (i_fu_tag),
        .o_alu_func (alu_func),
        .o_src_a    (src_a),
        .o_src_b    (src_b),
        .o_imm      (imm),
        .o_iaddr    (iaddr),
        .o_tag      (tag),
        .o_br_func  (br_func),
        .o_jmp      (jmp),
        .o_br       (br),
        .o_valid    (valid)
    );

    ieu_execute execute_i (
        .clk        (clk),
        .i_rst_n    (i_rst_n),
        .i_flush    (i_flush),
        .i_valid    (valid),
        .i_alu_func (alu_func),
        .i_src_a    (src_a),
        .i_src_b    (src_b),
        .i_imm      (imm),
        .i_iaddr    (iaddr),
        .i_tag      (tag),
        .i_br_func  (br_func),
        .i_jmp      (jmp),
        .i_br       (br),
        .o_data     (o_cdb_data),
        .o_addr     (o_cdb_addr),
        .o_tag      (o_cdb_tag),
        .o_redirect (o_cdb_redirect),
        .o_valid    (o_cdb_en)
    );

endmodule

// File: dv/ieu_checker.sv
`timescale 1ns/1ns

module ieu_checker (
    input logic clk,
    input logic i_rst_n,
    input logic i_flush,
    input logic i_fu_valid,
    input logic i_cdb_en,
    input logic i_cdb_redirect
);

    // redirect only ever rides on a valid result
    redirect_needs_en: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_cdb_redirect |-> i_cdb_en)
        else $error("redirect without cdb enable");

    // fixed two cycle latency when nothing flushes the op
    issue_to_cdb: assert property (@(posedge clk) disable iff (!i_rst_n)
        ($past(i_fu_valid, 2) && !$past(i_flush, 2) && !$past(i_flush, 1)) |-> i_cdb_en)
        else $error("issued op missing on cdb");

    // nothing shows up that was not issued two cycles before, covers reset too
    cdb_needs_issue: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_cdb_en |-> $past(i_fu_valid, 2))
        else $error("cdb enable without issue");

    no_cdb_after_flush: assert property (@(posedge clk) disable iff (!i_rst_n)
        ($past(i_flush, 1) || $past(i_flush, 2)) |-> !i_cdb_en)
        else $error("cdb enable after flush");

endmodule

bind ieu_top ieu_checker checker_i (
    .clk            (clk),
    .i_rst_n        (i_rst_n),
    .i_flush        (i_flush),
    .i_fu_valid     (i_fu_valid),
    .i_cdb_en       (o_cdb_en),
    .i_cdb_redirect (o_cdb_redirect)
);

// File: dv/ieu_tb.sv
`timescale 1ns/1ns

module ieu_tb;
    import ieu_pkg::*;

    logic        clk = 1'b0;
    logic        i_rst_n;
    logic        i_flush;
    logic        i_fu_valid;
    ieu_opcode_e i_fu_opcode;
    ieu_addr_t   i_fu_iaddr;
    ieu_data_t   i_fu_insn, i_fu_src_a, i_fu_src_b;
    ieu_tag_t    i_fu_tag;
    logic        o_cdb_en, o_cdb_redirect;
    ieu_data_t   o_cdb_data;
    ieu_addr_t   o_cdb_addr;
    ieu_tag_t    o_cdb_tag;

    // stimulus and expected values, one row per test
    string       t_name[64];
    ieu_opcode_e t_op[64];
    ieu_data_t   t_insn[64], t_a[64], t_b[64], t_exp_d[64];
    ieu_addr_t   t_iaddr[64], t_exp_a[64];
    logic        t_exp_r[64];
    int          n_rows = 0;
    int          pass_cnt = 0;
    int          fail_cnt = 0;
    bit          test_ok;
    integer      seed;

    ieu_top dut_i (.*);

    always #2 clk = ~clk;

    function automatic ieu_data_t enc_r(input logic [2:0] f3, input logic alt);
        return {1'b0, alt, 5'd0, 5'd2, 5'd1, f3, 5'd3, 7'b0110011};
    endfunction

    function automatic ieu_data_t enc_i(input logic [11:0] imm, input logic [2:0] f3);
        return {imm, 5'd1, f3, 5'd3, 7'b0010011};
    endfunction

    function automatic ieu_data_t enc_b(input logic [12:0] imm, input logic [2:0] f3);
        return {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic ieu_data_t enc_j(input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd1, 7'b1101111};
    endfunction

    // reference for register ops, straight from funct3 and bit 30
    function automatic ieu_data_t alu_ref(input logic [2:0] f3, input logic alt,
                                          input ieu_data_t a, input ieu_data_t b);
        ieu_data_t r;
        r = '0;
        case (f3)
            3'd0: r = alt ? a - b : a + b;
            3'd1: r = a << b[4:0];
            3'd2: r[0] = $signed(a) < $signed(b);
            3'd3: r[0] = a < b;
            3'd4: r = a ^ b;
            3'd5: r = alt ? ieu_data_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6: r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    task automatic add(input string name, input ieu_opcode_e op, input ieu_data_t insn,
                       input ieu_addr_t iaddr, input ieu_data_t a, input ieu_data_t b,
                       input ieu_data_t exp_d, input ieu_addr_t exp_a, input logic exp_r);
        t_name[n_rows] = name;
        t_op[n_rows] = op;
        t_insn[n_rows] = insn;
        t_iaddr[n_rows] = iaddr;
        t_a[n_rows] = a;
        t_b[n_rows] = b;
        t_exp_d[n_rows] = exp_d;
        t_exp_a[n_rows] = exp_a;
        t_exp_r[n_rows] = exp_r;
        n_rows++;
    endtask

    task automatic check_data(input string sig, input ieu_data_t exp, input ieu_data_t act);
        if (act !== exp) begin
            $display("** Error at %0t ns: %s expected %h, got %h", $time, sig, exp, act);
            test_ok = 1'b0;
        end
    endtask

    task automatic check_tag(input string sig, input ieu_tag_t exp, input ieu_tag_t act);
        if (act !== exp) begin
            $display("** Error at %0t ns: %s expected %0d, got %0d", $time, sig, exp, act);
            test_ok = 1'b0;
        end
    endtask

    task automatic check_flag(input string sig, input logic exp, input logic act);
        if (act !== exp) begin
            $display("** Error at %0t ns: %s expected %b, got %b", $time, sig, exp, act);
            test_ok = 1'b0;
        end
    endtask

    task automatic drive_row(input int idx);
        i_fu_valid = 1'b1;
        i_fu_opcode = t_op[idx];
        i_fu_insn = t_insn[idx];
        i_fu_iaddr = t_iaddr[idx];
        i_fu_src_a = t_a[idx];
        i_fu_src_b = t_b[idx];
        i_fu_tag = ieu_tag_t'(idx);
    endtask

    task automatic compare_row(input int idx);
        check_flag("o_cdb_en", 1'b1, o_cdb_en);
        check_data("o_cdb_data", t_exp_d[idx], o_cdb_data);
        check_data("o_cdb_addr", t_exp_a[idx], o_cdb_addr);
        check_tag("o_cdb_tag", ieu_tag_t'(idx), o_cdb_tag);
        check_flag("o_cdb_redirect", t_exp_r[idx], o_cdb_redirect);
    endtask

    task automatic finish_test(input string name);
        if (test_ok) pass_cnt++;
        else fail_cnt++;
        $display("test %-10s %s", name, test_ok ? "ok" : "FAILED");
    endtask

    task automatic run_row(input int idx);
        int n;
        test_ok = 1'b1;
        @(negedge clk);
        drive_row(idx);
        @(negedge clk);
        i_fu_valid = 1'b0;
        n = 1;
        while (!o_cdb_en && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (o_cdb_en) begin
            compare_row(idx);
        end else begin
            $display("timeout: no CDB result within 20 cycles for %s", t_name[idx]);
            test_ok = 1'b0;
        end
        finish_test(t_name[idx]);
    endtask

    initial begin
        ieu_data_t a, b;
        logic [2:0] f3;
        seed = 32'h63f8;
        i_rst_n = 1'b0;
        i_flush = 1'b0;
        i_fu_valid = 1'b0;
        i_fu_opcode = OP;
        i_fu_iaddr = '0;
        i_fu_insn = '0;
        i_fu_src_a = '0;
        i_fu_src_b = '0;
        i_fu_tag = '0;

        add("add", OP, enc_r(3'd0, 0), 32'h1000, 5, 7, 12, 32'h1004, 0);
        add("sub", OP, enc_r(3'd0, 1), 32'h1000, 5, 7, 32'hfffffffe, 32'h1004, 0);
        add("and", OP, enc_r(3'd7, 0), 32'h1000, 32'hf0f0ff00, 32'h0ff00ff0,
            32'h00f00f00, 32'h1004, 0);
        add("or", OP, enc_r(3'd6, 0), 32'h1000, 32'hf0f0ff00, 32'h0ff00ff0,
            32'hfff0fff0, 32'h1004, 0);
        add("xor", OP, enc_r(3'd4, 0), 32'h1000, 32'hf0f0ff00, 32'h0ff00ff0,
            32'hff00f0f0, 32'h1004, 0);
        add("sll", OP, enc_r(3'd1, 0), 32'h1000, 1, 32'h24, 32'h10, 32'h1004, 0);
        add("srl", OP, enc_r(3'd5, 0), 32'h1000, 32'h80000000, 31, 1, 32'h1004, 0);
        add("sra", OP, enc_r(3'd5, 1), 32'h1000, 32'h80000000, 4, 32'hf8000000, 32'h1004, 0);
        add("slt", OP, enc_r(3'd2, 0), 32'h1000, 32'hffffffff, 1, 1, 32'h1004, 0);
        add("sltu", OP, enc_r(3'd3, 0), 32'h1000, 32'hffffffff, 1, 0, 32'h1004, 0);
        add("addi_neg", OP_IMM, enc_i(12'hffd, 3'd0), 32'h1000, 10, 0, 7, 32'h1004, 0);
        add("addi_b30", OP_IMM, enc_i(12'h400, 3'd0), 32'h1000, 0, 0, 32'h400, 32'h1004, 0);
        add("srli", OP_IMM, enc_i(12'h004, 3'd5), 32'h1000, 32'hf0000000, 0,
            32'h0f000000, 32'h1004, 0);
        add("srai", OP_IMM, enc_i(12'h404, 3'd5), 32'h1000, 32'hf0000000, 0,
            32'hff000000, 32'h1004, 0);
        add("slti", OP_IMM, enc_i(12'hffd, 3'd2), 32'h1000, 32'hfffffffb, 0, 1, 32'h1004, 0);
        add("sltiu", OP_IMM, enc_i(12'hfff, 3'd3), 32'h1000, 5, 0, 1, 32'h1004, 0);
        add("xori", OP_IMM, enc_i(12'hfff, 3'd4), 32'h1000, 32'hff, 0, 32'hffffff00,
            32'h1004, 0);
        add("lui", LUI, {20'h12345, 12'h1b7}, 32'h1000, 9, 9, 32'h12345000, 32'h1004, 0);
        add("auipc", AUIPC, {20'h00002, 12'h197}, 32'h1000, 9, 9, 32'h3000, 32'h1004, 0);
        add("jal_fwd", JAL, enc_j(21'h000800), 32'h1000, 0, 0, 32'h1004, 32'h1800, 1);
        add("jal_back", JAL, enc_j(21'h1ffff0), 32'h1000, 0, 0, 32'h1004, 32'h0ff0, 1);
        add("jalr", JALR, enc_i(12'h010, 3'd0), 32'h1000, 32'h2001, 0, 32'h1004, 32'h2010, 1);
        add("jalr_neg", JALR, enc_i(12'hfff, 3'd0), 32'h1000, 32'h3000, 0, 32'h1004,
            32'h2ffe, 1);
        add("beq_t", BRANCH, enc_b(13'h0040, 3'd0), 32'h1000, 5, 5, 0, 32'h1040, 1);
        add("beq_n", BRANCH, enc_b(13'h0040, 3'd0), 32'h1000, 5, 6, 0, 32'h1004, 0);
        add("beq_back", BRANCH, enc_b(13'h1ff8, 3'd0), 32'h1000, 3, 3, 0, 32'h0ff8, 1);
        add("bne_t", BRANCH, enc_b(13'h0040, 3'd1), 32'h1000, 5, 6, 0, 32'h1040, 1);
        add("bne_n", BRANCH, enc_b(13'h0040, 3'd1), 32'h1000, 6, 6, 0, 32'h1004, 0);
        add("blt_t", BRANCH, enc_b(13'h0040, 3'd4), 32'h1000, 32'hffffffff, 1, 0, 32'h1040, 1);
        add("blt_n", BRANCH, enc_b(13'h0040, 3'd4), 32'h1000, 1, 32'hffffffff, 0, 32'h1004, 0);
        add("bltu_n", BRANCH, enc_b(13'h0040, 3'd6), 32'h1000, 32'hffffffff, 1, 0, 32'h1004, 0);
        add("bltu_t", BRANCH, enc_b(13'h0040, 3'd6), 32'h1000, 1, 2, 0, 32'h1040, 1);
        add("bge_t", BRANCH, enc_b(13'h0040, 3'd5), 32'h1000, 1, 32'hffffffff, 0, 32'h1040, 1);
        add("bge_n", BRANCH, enc_b(13'h0040, 3'd5), 32'h1000, 32'hfffffffe, 32'hffffffff,
            0, 32'h1004, 0);
        add("bgeu_n", BRANCH, enc_b(13'h0040, 3'd7), 32'h1000, 1, 32'hffffffff, 0, 32'h1004, 0);
        add("bgeu_t", BRANCH, enc_b(13'h0040, 3'd7), 32'h1000, 2, 2, 0, 32'h1040, 1);
        for (int f = 0; f < 10; f++) begin
            a = $random(seed);
            b = $random(seed);
            f3 = (f == 9) ? 3'd5 : f[2:0]; // last two with bit 30 are sub and sra
            add("rand_op", OP, enc_r(f3, f >= 8), 32'h2000, a, b,
                alu_ref(f3, f >= 8, a, b), 32'h2004, 0);
        end

        repeat (8) @(posedge clk);
        @(negedge clk);
        i_rst_n = 1'b1;
        test_ok = 1'b1;
        check_flag("o_cdb_en", 1'b0, o_cdb_en);
        check_flag("o_cdb_redirect", 1'b0, o_cdb_redirect);
        finish_test("reset");

        for (int i = 0; i < n_rows; i++) run_row(i);

        // back to back, result of issue c seen at negedge c+2
        test_ok = 1'b1;
        for (int c = 0; c < 8; c++) begin
            @(negedge clk);
            if (c >= 2) compare_row(c - 2);
            else check_flag("o_cdb_en", 1'b0, o_cdb_en);
            if (c < 6) drive_row(c);
            else i_fu_valid = 1'b0;
        end
        @(negedge clk);
        check_flag("o_cdb_en", 1'b0, o_cdb_en);
        finish_test("b2b");

        // one op in decode plus one issued with the flush, both dropped
        test_ok = 1'b1;
        @(negedge clk);
        drive_row(0);
        @(negedge clk);
        drive_row(1);
        i_flush = 1'b1;
        @(negedge clk);
        i_flush = 1'b0;
        i_fu_valid = 1'b0;
        for (int c = 0; c < 3; c++) begin
            check_flag("o_cdb_en", 1'b0, o_cdb_en);
            @(negedge clk);
        end
        finish_test("flush");
        run_row(3);

        $display("%0d tests passed, %0d tests failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: list.f
+incdir+src
src/ieu_pkg.sv
src/ieu_decode.sv
src/ieu_execute.sv
src/ieu_top.sv
dv/ieu_checker.sv
dv/ieu_tb.sv

// File: Makefile
.PHONY: all run lint clean

all: run

obj_dir/Vieu_tb: list.f src/*.sv src/*.svh dv/*.sv
	verilator --binary --assert --timing -f list.f --top-module ieu_tb -o Vieu_tb

run: obj_dir/Vieu_tb
	-./obj_dir/Vieu_tb > sim.log 2>&1
	@cat sim.log
	@if grep -q "Test failures found" sim.log; then exit 1; fi
	@if ! grep -q "All tests passed!" sim.log; then exit 1; fi

lint:
	verilator --lint-only --timing -f list.f --top-module ieu_tb

clean:
	rm -rf obj_dir sim.log
